//--- logic/axi_pkg.sv
package axi_pkg;

	// response codes on r and b channels
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	// transfer size, log2 of bytes per beat
	typedef logic [2:0] size_t;

	localparam size_t SIZE_WORD = 3'd2;

	// burst length minus one, and burst type
	typedef logic [7:0] len_t;
	typedef logic [1:0] burst_t;

endpackage

//--- logic/axi_word_ram.sv
`timescale 1ns/1ns
`include "mmu_consts.svh"

module axi_word_ram #(
	parameter int ADDR_BITS = `MEM_ADDR_BITS
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [31:0]     araddr,
	input  logic            arvalid,
	input  axi_pkg::size_t  arsize,
	input  axi_pkg::len_t   arlen,
	input  axi_pkg::burst_t arburst,
	output logic            arready,
	output logic [31:0]     rdata,
	output axi_pkg::resp_e  rresp,
	output logic            rvalid,
	output logic            rlast,
	input  logic            rready,
	input  logic [31:0]     awaddr,
	input  logic            awvalid,
	output logic            awready,
	input  logic [31:0]     wdata,
	input  logic [3:0]      wstrb,
	input  logic            wvalid,
	output logic            wready,
	output axi_pkg::resp_e  bresp,
	output logic            bvalid,
	input  logic            bready
);

	localparam int WORDS = 2 ** (ADDR_BITS - 2);

	logic [31:0]          mem [WORDS];
	logic                 ar_fire;
	logic                 wr_fire;
	logic                 ar_ok;
	logic                 aw_ok;
	logic [ADDR_BITS-3:0] ar_idx;
	logic [ADDR_BITS-3:0] aw_idx;

	// size, len and burst are accepted as given, every transfer is one full word beat
	assign arready = !rvalid;
	assign ar_fire = arvalid && arready;
	// aw and w are taken together only
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign rlast   = rvalid;

	// range check, any bit above the array decodes to nothing
	assign ar_ok  = araddr[31:ADDR_BITS] == '0;
	assign aw_ok  = awaddr[31:ADDR_BITS] == '0;
	assign ar_idx = araddr[ADDR_BITS-1:2];
	assign aw_idx = awaddr[ADDR_BITS-1:2];

	// ------------------------------------------------------------------------
	// response handshakes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (ar_fire) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (wr_fire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_fire) begin
			rdata <= ar_ok ? mem[ar_idx] : '0;
			rresp <= ar_ok ? axi_pkg::OKAY : axi_pkg::DECERR;
		end
		if (wr_fire) begin
			bresp <= aw_ok ? axi_pkg::OKAY : axi_pkg::DECERR;
		end
	end

	// ------------------------------------------------------------------------
	// storage with byte strobes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_fire && aw_ok) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

endmodule

//--- logic/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// byte address bits of the memory, 16 KiB
`define MEM_ADDR_BITS 14

// pte valid flag position
`define PTE_V_BIT 0

// page offset width
`define PAGE_BITS 12

`endif

//--- logic/mmu_subsys_top.sv
`timescale 1ns/1ns
`include "mmu_consts.svh"

module mmu_subsys_top (
	input  logic            clk,
	input  logic            rst,
	input  logic [31:0]     araddr,
	input  logic            arvalid,
	input  axi_pkg::size_t  arsize,
	input  axi_pkg::len_t   arlen,
	input  axi_pkg::burst_t arburst,
	input  sv32_pkg::satp_t arsatp,
	output logic            arready,
	output logic [31:0]     rdata,
	output axi_pkg::resp_e  rresp,
	output logic            rvalid,
	output logic            rlast,
	input  logic            rready,
	input  logic [31:0]     awaddr,
	input  logic            awvalid,
	input  sv32_pkg::satp_t awsatp,
	output logic            awready,
	input  logic [31:0]     wdata,
	input  logic [3:0]      wstrb,
	input  logic            wvalid,
	output logic            wready,
	output axi_pkg::resp_e  bresp,
	output logic            bvalid,
	input  logic            bready
);

	// mmu to memory
	logic [31:0]     mem_araddr;
	logic            mem_arvalid;
	axi_pkg::size_t  mem_arsize;
	axi_pkg::len_t   mem_arlen;
	axi_pkg::burst_t mem_arburst;
	logic            mem_arready;
	logic [31:0]     mem_rdata;
	axi_pkg::resp_e  mem_rresp;
	logic            mem_rvalid;
	logic            mem_rlast;
	logic            mem_rready;
	logic [31:0]     mem_awaddr;
	logic            mem_awvalid;
	logic            mem_awready;
	logic [31:0]     mem_wdata;
	logic [3:0]      mem_wstrb;
	logic            mem_wvalid;
	logic            mem_wready;
	axi_pkg::resp_e  mem_bresp;
	logic            mem_bvalid;
	logic            mem_bready;

	sv32_mmu u_mmu (
		.clk         (clk),
		.rst         (rst),
		.in_araddr   (araddr),
		.in_arvalid  (arvalid),
		.in_arsize   (arsize),
		.in_arlen    (arlen),
		.in_arburst  (arburst),
		.in_arsatp   (arsatp),
		.in_arready  (arready),
		.in_rdata    (rdata),
		.in_rresp    (rresp),
		.in_rvalid   (rvalid),
		.in_rlast    (rlast),
		.in_rready   (rready),
		.in_awaddr   (awaddr),
		.in_awvalid  (awvalid),
		.in_awsatp   (awsatp),
		.in_awready  (awready),
		.in_wdata    (wdata),
		.in_wstrb    (wstrb),
		.in_wvalid   (wvalid),
		.in_wready   (wready),
		.in_bresp    (bresp),
		.in_bvalid   (bvalid),
		.in_bready   (bready),
		.out_araddr  (mem_araddr),
		.out_arvalid (mem_arvalid),
		.out_arsize  (mem_arsize),
		.out_arlen   (mem_arlen),
		.out_arburst (mem_arburst),
		.out_arready (mem_arready),
		.out_rdata   (mem_rdata),
		.out_rresp   (mem_rresp),
		.out_rvalid  (mem_rvalid),
		.out_rlast   (mem_rlast),
		.out_rready  (mem_rready),
		.out_awaddr  (mem_awaddr),
		.out_awvalid (mem_awvalid),
		.out_awready (mem_awready),
		.out_wdata   (mem_wdata),
		.out_wstrb   (mem_wstrb),
		.out_wvalid  (mem_wvalid),
		.out_wready  (mem_wready),
		.out_bresp   (mem_bresp),
		.out_bvalid  (mem_bvalid),
		.out_bready  (mem_bready)
	);

	// page tables and data share this one memory
	axi_word_ram #(
		.ADDR_BITS(`MEM_ADDR_BITS)
	) u_ram (
		.clk     (clk),
		.rst     (rst),
		.araddr  (mem_araddr),
		.arvalid (mem_arvalid),
		.arsize  (mem_arsize),
		.arlen   (mem_arlen),
		.arburst (mem_arburst),
		.arready (mem_arready),
		.rdata   (mem_rdata),
		.rresp   (mem_rresp),
		.rvalid  (mem_rvalid),
		.rlast   (mem_rlast),
		.rready  (mem_rready),
		.awaddr  (mem_awaddr),
		.awvalid (mem_awvalid),
		.awready (mem_awready),
		.wdata   (mem_wdata),
		.wstrb   (mem_wstrb),
		.wvalid  (mem_wvalid),
		.wready  (mem_wready),
		.bresp   (mem_bresp),
		.bvalid  (mem_bvalid),
		.bready  (mem_bready)
	);

endmodule

//--- logic/sv32_mmu.sv
`timescale 1ns/1ns
`include "mmu_consts.svh"

module sv32_mmu (
	input  logic                clk,
	input  logic                rst,
	// cpu side
	input  logic [31:0]         in_araddr,
	input  logic                in_arvalid,
	input  axi_pkg::size_t      in_arsize,
	input  axi_pkg::len_t       in_arlen,
	input  axi_pkg::burst_t     in_arburst,
	input  sv32_pkg::satp_t     in_arsatp,
	output logic                in_arready,
	output logic [31:0]         in_rdata,
	output axi_pkg::resp_e      in_rresp,
	output logic                in_rvalid,
	output logic                in_rlast,
	input  logic                in_rready,
	input  logic [31:0]         in_awaddr,
	input  logic                in_awvalid,
	input  sv32_pkg::satp_t     in_awsatp,
	output logic                in_awready,
	input  logic [31:0]         in_wdata,
	input  logic [3:0]          in_wstrb,
	input  logic                in_wvalid,
	output logic                in_wready,
	output axi_pkg::resp_e      in_bresp,
	output logic                in_bvalid,
	input  logic                in_bready,
	// memory side
	output logic [31:0]         out_araddr,
	output logic                out_arvalid,
	output axi_pkg::size_t      out_arsize,
	output axi_pkg::len_t       out_arlen,
	output axi_pkg::burst_t     out_arburst,
	input  logic                out_arready,
	input  logic [31:0]         out_rdata,
	input  axi_pkg::resp_e      out_rresp,
	input  logic                out_rvalid,
	input  logic                out_rlast,
	output logic                out_rready,
	output logic [31:0]         out_awaddr,
	output logic                out_awvalid,
	input  logic                out_awready,
	output logic [31:0]         out_wdata,
	output logic [3:0]          out_wstrb,
	output logic                out_wvalid,
	input  logic                out_wready,
	input  axi_pkg::resp_e      out_bresp,
	input  logic                out_bvalid,
	output logic                out_bready
);

	sv32_pkg::mmu_state_e  state;
	sv32_pkg::mmu_state_e  state_nxt;
	sv32_pkg::mmu_state_e  done_st;
	logic                  is_wr;
	sv32_pkg::satp_t       satp_q;
	sv32_pkg::mem_word_u   pte1_q;
	sv32_pkg::mem_word_u   leaf_q;
	sv32_pkg::mem_word_u   rd_word;
	logic [31:0]           rdata_q;
	axi_pkg::resp_e        resp_q;

	sv32_pkg::vaddr_t      va;
	logic [`PAGE_BITS-1:0] page_off;
	logic [31:0]           pte1_addr;
	logic [31:0]           pte2_addr;
	logic [31:0]           paddr;
	logic [31:0]           walk_araddr;
	logic                  wr_req;
	logic                  virt_req;
	logic                  bypass;
	logic                  pte_bad;
	logic                  walk_ar;
	logic                  walk_r;
	logic                  walk_aw;
	logic                  walk_w;
	logic                  rd_done;
	logic                  wr_done;

	// ------------------------------------------------------------------------
	// mode select and address formation
	// ------------------------------------------------------------------------
	assign wr_req   = in_awvalid && in_wvalid;
	assign virt_req = (in_arvalid && in_arsatp.mode) || (in_awvalid && in_awsatp.mode);
	// a request with the mode bit is held back, never forwarded
	assign bypass   = (state == sv32_pkg::ST_BARE) && !virt_req;

	// master holds its request until the done state, so read it live
	assign va       = is_wr ? in_awaddr : in_araddr;
	assign page_off = va.offset;
	assign rd_word  = out_rdata;

	assign pte1_addr = {satp_q.root_ppn, va.vpn1, 2'b00};
	assign pte2_addr = {pte1_q.pte.ppn1, pte1_q.pte.ppn0, va.vpn0, 2'b00};
	assign paddr     = {leaf_q.pte.ppn1, leaf_q.pte.ppn0, page_off};

	assign pte_bad = (out_rresp != axi_pkg::OKAY) || !rd_word.pte.flags[`PTE_V_BIT];
	assign done_st = is_wr ? sv32_pkg::ST_WR_DONE : sv32_pkg::ST_RD_DONE;

	// ------------------------------------------------------------------------
	// walk fsm
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			sv32_pkg::ST_BARE: begin
				if (virt_req) begin
					state_nxt = sv32_pkg::ST_IDLE;
				end
			end
			sv32_pkg::ST_IDLE: begin
				if (wr_req || in_arvalid) begin
					state_nxt = sv32_pkg::ST_PTE1_REQ;
				end
			end
			sv32_pkg::ST_PTE1_REQ: begin
				if (out_arready) begin
					state_nxt = sv32_pkg::ST_PTE1_WAIT;
				end
			end
			sv32_pkg::ST_PTE1_WAIT: begin
				if (out_rvalid) begin
					state_nxt = pte_bad ? done_st : sv32_pkg::ST_PTE2_REQ;
				end
			end
			sv32_pkg::ST_PTE2_REQ: begin
				if (out_arready) begin
					state_nxt = sv32_pkg::ST_PTE2_WAIT;
				end
			end
			sv32_pkg::ST_PTE2_WAIT: begin
				if (out_rvalid && pte_bad) begin
					state_nxt = done_st;
				end else if (out_rvalid) begin
					state_nxt = is_wr ? sv32_pkg::ST_WR_REQ : sv32_pkg::ST_RD_REQ;
				end
			end
			sv32_pkg::ST_RD_REQ: begin
				if (out_arready) begin
					state_nxt = sv32_pkg::ST_RD_WAIT;
				end
			end
			sv32_pkg::ST_RD_WAIT: begin
				if (out_rvalid) begin
					state_nxt = sv32_pkg::ST_RD_DONE;
				end
			end
			sv32_pkg::ST_WR_REQ: begin
				if (out_awready && out_wready) begin
					state_nxt = sv32_pkg::ST_WR_RESP;
				end else if (out_awready) begin
					state_nxt = sv32_pkg::ST_WR_W;
				end else if (out_wready) begin
					state_nxt = sv32_pkg::ST_WR_AW;
				end
			end
			sv32_pkg::ST_WR_AW: begin
				if (out_awready) begin
					state_nxt = sv32_pkg::ST_WR_RESP;
				end
			end
			sv32_pkg::ST_WR_W: begin
				if (out_wready) begin
					state_nxt = sv32_pkg::ST_WR_RESP;
				end
			end
			sv32_pkg::ST_WR_RESP: begin
				if (out_bvalid) begin
					state_nxt = sv32_pkg::ST_WR_DONE;
				end
			end
			sv32_pkg::ST_RD_DONE: begin
				if (in_rready) begin
					state_nxt = sv32_pkg::ST_IDLE;
				end
			end
			sv32_pkg::ST_WR_DONE: begin
				if (in_bready) begin
					state_nxt = sv32_pkg::ST_IDLE;
				end
			end
			default: state_nxt = sv32_pkg::ST_BARE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sv32_pkg::ST_BARE;
			is_wr <= 1'b0;
		end else begin
			state <= state_nxt;
			// writes win when both channels are offered
			if (state == sv32_pkg::ST_IDLE) begin
				is_wr <= wr_req;
			end
		end
	end

	// request satp, pte words and the response for the master
	always_ff @(posedge clk) begin
		case (state)
			sv32_pkg::ST_IDLE: begin
				satp_q <= wr_req ? in_awsatp : in_arsatp;
			end
			sv32_pkg::ST_PTE1_WAIT: begin
				// fault values, replaced by the final access if the walk completes
				if (out_rvalid) begin
					pte1_q  <= rd_word;
					rdata_q <= '0;
					resp_q  <= axi_pkg::SLVERR;
				end
			end
			sv32_pkg::ST_PTE2_WAIT: begin
				if (out_rvalid) begin
					leaf_q  <= rd_word;
					rdata_q <= '0;
					resp_q  <= axi_pkg::SLVERR;
				end
			end
			sv32_pkg::ST_RD_WAIT: begin
				if (out_rvalid) begin
					rdata_q <= rd_word.data;
					resp_q  <= out_rresp;
				end
			end
			sv32_pkg::ST_WR_RESP: begin
				if (out_bvalid) begin
					resp_q <= out_bresp;
				end
			end
			default: ;
		endcase
	end

	// ------------------------------------------------------------------------
	// output multiplexers
	// ------------------------------------------------------------------------
	always_comb begin
		case (state)
			sv32_pkg::ST_PTE1_REQ: walk_araddr = pte1_addr;
			sv32_pkg::ST_PTE2_REQ: walk_araddr = pte2_addr;
			default:               walk_araddr = paddr;
		endcase
	end

	assign walk_ar = state inside {sv32_pkg::ST_PTE1_REQ, sv32_pkg::ST_PTE2_REQ,
		sv32_pkg::ST_RD_REQ};
	assign walk_r  = state inside {sv32_pkg::ST_PTE1_WAIT, sv32_pkg::ST_PTE2_WAIT,
		sv32_pkg::ST_RD_WAIT};
	assign walk_aw = state inside {sv32_pkg::ST_WR_REQ, sv32_pkg::ST_WR_AW};
	assign walk_w  = state inside {sv32_pkg::ST_WR_REQ, sv32_pkg::ST_WR_W};
	assign rd_done = state == sv32_pkg::ST_RD_DONE;
	assign wr_done = state == sv32_pkg::ST_WR_DONE;

	assign out_araddr  = bypass ? in_araddr : walk_araddr;
	assign out_arvalid = bypass ? in_arvalid : walk_ar;
	// pte fetches are always whole words
	assign out_arsize  = (bypass || state == sv32_pkg::ST_RD_REQ) ? in_arsize :
		axi_pkg::SIZE_WORD;
	assign out_arlen   = in_arlen;
	assign out_arburst = in_arburst;
	assign out_rready  = bypass ? in_rready : walk_r;
	assign out_awaddr  = bypass ? in_awaddr : paddr;
	assign out_awvalid = bypass ? in_awvalid : walk_aw;
	assign out_wdata   = in_wdata;
	assign out_wstrb   = in_wstrb;
	assign out_wvalid  = bypass ? in_wvalid : walk_w;
	assign out_bready  = bypass ? in_bready : (state == sv32_pkg::ST_WR_RESP);

	assign in_arready = bypass ? out_arready : rd_done;
	assign in_rdata   = bypass ? out_rdata : rdata_q;
	assign in_rresp   = bypass ? out_rresp : resp_q;
	assign in_rvalid  = bypass ? out_rvalid : rd_done;
	assign in_rlast   = bypass ? out_rlast : rd_done;
	assign in_awready = bypass ? out_awready : wr_done;
	assign in_wready  = bypass ? out_wready : wr_done;
	assign in_bresp   = bypass ? out_bresp : resp_q;
	assign in_bvalid  = bypass ? out_bvalid : wr_done;

endmodule

//--- logic/sv32_pkg.sv
package sv32_pkg;

	// virtual address split for a two level walk
	typedef struct packed {
		logic [9:0]  vpn1;
		logic [9:0]  vpn0;
		logic [11:0] offset;
	} vaddr_t;

	// satp as carried with each request
	typedef struct packed {
		logic        mode;
		logic [10:0] asid;
		logic [19:0] root_ppn;
	} satp_t;

	// page table entry, flags[0] is the valid bit
	typedef struct packed {
		logic [1:0] reserved;
		logic [9:0] ppn1;
		logic [9:0] ppn0;
		logic [9:0] flags;
	} pte_t;

	// one memory word, seen as data or as a pte
	typedef union packed {
		logic [31:0] data;
		pte_t        pte;
	} mem_word_u;

	// mmu fsm
	typedef enum logic [3:0] {
		ST_BARE, ST_IDLE,
		ST_PTE1_REQ, ST_PTE1_WAIT,
		ST_PTE2_REQ, ST_PTE2_WAIT,
		ST_RD_REQ, ST_RD_WAIT,
		ST_WR_REQ, ST_WR_AW, ST_WR_W, ST_WR_RESP,
		ST_RD_DONE, ST_WR_DONE
	} mmu_state_e;

endpackage

//--- mmu_subsys.f
+incdir+logic
logic/axi_pkg.sv
logic/sv32_pkg.sv
logic/axi_word_ram.sv
logic/sv32_mmu.sv
logic/mmu_subsys_top.sv
tests/tb_mmu_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mmu subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ns --top-module tb_mmu_subsys \
	-f mmu_subsys.f -o tb_mmu_subsys
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_mmu_subsys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "Test passed" sim.log; then
	echo "simulation ended without a pass report"
	exit 1
fi

exit 0

//--- tests/tb_mmu_subsys.sv
`timescale 1ns/1ns
`include "mmu_consts.svh"

module tb_mmu_subsys;

	localparam int NUM_TXN = 39;
	localparam int RESET_CYCLES = 8;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * NUM_TXN;
	localparam int MODEL_WORDS = 2 ** (`MEM_ADDR_BITS - 2);
	localparam logic [31:0] SATP_BARE = 32'h0000_0000;
	// mode bit set and root table at ppn 1
	localparam logic [31:0] SATP_VIRT = 32'h8000_0001;

	logic            clk;
	logic            rst;
	logic [31:0]     araddr;
	logic            arvalid;
	axi_pkg::size_t  arsize;
	axi_pkg::len_t   arlen;
	axi_pkg::burst_t arburst;
	sv32_pkg::satp_t arsatp;
	logic            arready;
	logic [31:0]     rdata;
	axi_pkg::resp_e  rresp;
	logic            rvalid;
	logic            rlast;
	logic            rready;
	logic [31:0]     awaddr;
	logic            awvalid;
	sv32_pkg::satp_t awsatp;
	logic            awready;
	logic [31:0]     wdata;
	logic [3:0]      wstrb;
	logic            wvalid;
	logic            wready;
	axi_pkg::resp_e  bresp;
	logic            bvalid;
	logic            bready;

	// physical memory as the testbench expects it
	logic [31:0]     model [MODEL_WORDS];
	int              errors = 0;
	int              checks = 0;

	mmu_subsys_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: no end of test after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// checks and reference model
	// ------------------------------------------------------------------------
	task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s, got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input axi_pkg::resp_e got, input axi_pkg::resp_e exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s, got %s expected %s", $time, what,
				got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input logic got, input string what);
		checks++;
		if (got !== 1'b1) begin
			errors++;
			$display("ERR %0t: %s, signal is %b", $time, what, got);
		end
	endtask

	// byte merge for an in-range write
	task automatic model_write(input logic [31:0] pa, input logic [31:0] data,
		input logic [3:0] strb);
		if (pa < (32'd1 << `MEM_ADDR_BITS)) begin
			for (int i = 0; i < 4; i++) begin
				if (strb[i]) begin
					model[pa[`MEM_ADDR_BITS-1:2]][8*i +: 8] = data[8*i +: 8];
				end
			end
		end
	endtask

	function automatic logic [31:0] model_word(input logic [31:0] pa);
		return model[pa[`MEM_ADDR_BITS-1:2]];
	endfunction

	// ppn above the flags and the valid flag at its own position
	function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic valid);
		logic [31:0] pte;
		pte = {2'b00, ppn, 10'b0};
		pte[`PTE_V_BIT] = valid;
		return pte;
	endfunction

	function automatic int random_hold();
		return $urandom_range(0, 5);
	endfunction

	// ------------------------------------------------------------------------
	// bus transactions that start and return 1 ns after a rising edge
	// ------------------------------------------------------------------------
	task automatic bus_read(input logic [31:0] addr, input sv32_pkg::satp_t satp,
		input int hold, output logic [31:0] data, output axi_pkg::resp_e resp);
		logic [31:0]    first_data;
		axi_pkg::resp_e first_resp;
		araddr = addr;
		arsatp = satp;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		first_data = rdata;
		first_resp = rresp;
		// response must not move while rready is low
		repeat (hold) begin
			@(negedge clk);
			check_flag(rvalid, "rvalid held under back-pressure");
			check_word(rdata, first_data, "rdata held under back-pressure");
			check_resp(rresp, first_resp, "rresp held under back-pressure");
		end
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(negedge clk);
		check_flag(rvalid, "rvalid at handshake");
		check_flag(rlast, "rlast with single beat");
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input sv32_pkg::satp_t satp,
		input logic [31:0] data, input logic [3:0] strb, input int hold,
		output axi_pkg::resp_e resp);
		axi_pkg::resp_e first_resp;
		awaddr = addr;
		awsatp = satp;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		while (!(awready && wready)) @(negedge clk);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		first_resp = bresp;
		repeat (hold) begin
			@(negedge clk);
			check_flag(bvalid, "bvalid held under back-pressure");
			check_resp(bresp, first_resp, "bresp held under back-pressure");
		end
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(negedge clk);
		check_flag(bvalid, "bvalid at handshake");
		resp = bresp;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
		axi_pkg::resp_e resp;
		bus_write(addr, SATP_BARE, data, 4'hf, random_hold(), resp);
		check_resp(resp, axi_pkg::OKAY, "bare store response");
		model_write(addr, data, 4'hf);
	endtask

	task automatic read_expect(input logic [31:0] addr, input logic [31:0] satp,
		input logic [31:0] pa, input int hold, input string what);
		logic [31:0]    data;
		axi_pkg::resp_e resp;
		bus_read(addr, satp, hold, data, resp);
		check_resp(resp, axi_pkg::OKAY, what);
		check_word(data, model_word(pa), what);
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic bare_readback();
		axi_pkg::resp_e resp;
		logic [31:0]    d;
		store_word(32'h0000_0100, $urandom);
		read_expect(32'h0000_0100, SATP_BARE, 32'h0000_0100, random_hold(), "bare full word");
		d = $urandom;
		bus_write(32'h0000_0100, SATP_BARE, d, 4'b0101, random_hold(), resp);
		check_resp(resp, axi_pkg::OKAY, "bare partial write");
		model_write(32'h0000_0100, d, 4'b0101);
		read_expect(32'h0000_0100, SATP_BARE, 32'h0000_0100, random_hold(), "bare merged word");
	endtask

	task automatic bare_out_of_range();
		logic [31:0]    data;
		axi_pkg::resp_e resp;
		store_word(32'h0000_0000, $urandom);
		bus_read(32'h0001_0000, SATP_BARE, random_hold(), data, resp);
		check_resp(resp, axi_pkg::DECERR, "read above memory");
		check_word(data, 32'h0, "read data above memory");
		bus_read(32'h8000_0000, SATP_BARE, random_hold(), data, resp);
		check_resp(resp, axi_pkg::DECERR, "read at top bit");
		check_word(data, 32'h0, "read data at top bit");
		// would alias word 0 without the range check
		bus_write(32'h0000_4000, SATP_BARE, $urandom, 4'hf, random_hold(), resp);
		check_resp(resp, axi_pkg::DECERR, "write above memory");
		read_expect(32'h0000_0000, SATP_BARE, 32'h0000_0000, random_hold(), "word 0 untouched");
	endtask

	task automatic translated_read();
		// root table at 0x1000 and leaf table at 0x2000
		store_word(32'h0000_1004, make_pte(20'd2, 1'b1));
		store_word(32'h0000_1008, make_pte(20'd3, 1'b0));
		store_word(32'h0000_2000, make_pte(20'd3, 1'b1));
		store_word(32'h0000_2004, make_pte(20'd0, 1'b1));
		store_word(32'h0000_2008, make_pte(20'd3, 1'b0));
		store_word(32'h0000_200c, make_pte(20'd3, 1'b1));
		store_word(32'h0000_3010, $urandom);
		store_word(32'h0000_0020, $urandom);
		store_word(32'h0000_3040, $urandom);
		read_expect(32'h0040_0010, SATP_VIRT, 32'h0000_3010, random_hold(), "virt page 0");
		read_expect(32'h0040_1020, SATP_VIRT, 32'h0000_0020, random_hold(), "virt page 1");
		read_expect(32'h0040_3010, SATP_VIRT, 32'h0000_3010, random_hold(), "virt alias page");
	endtask

	task automatic translated_write();
		axi_pkg::resp_e resp;
		logic [31:0]    d;
		d = $urandom;
		bus_write(32'h0040_0040, SATP_VIRT, d, 4'hf, random_hold(), resp);
		check_resp(resp, axi_pkg::OKAY, "virt write");
		model_write(32'h0000_3040, d, 4'hf);
		read_expect(32'h0040_0040, SATP_VIRT, 32'h0000_3040, random_hold(), "virt readback");
		read_expect(32'h0040_3040, SATP_VIRT, 32'h0000_3040, random_hold(), "alias readback");
		d = $urandom;
		bus_write(32'h0040_1020, SATP_VIRT, d, 4'b1100, random_hold(), resp);
		check_resp(resp, axi_pkg::OKAY, "virt partial write");
		model_write(32'h0000_0020, d, 4'b1100);
		read_expect(32'h0040_1020, SATP_VIRT, 32'h0000_0020, random_hold(), "virt merged");
	endtask

	task automatic invalid_pte();
		logic [31:0]    data;
		axi_pkg::resp_e resp;
		// vpn1 2 has an invalid root entry
		bus_read(32'h0080_0040, SATP_VIRT, random_hold(), data, resp);
		check_resp(resp, axi_pkg::SLVERR, "read, invalid root pte");
		check_word(data, 32'h0, "read data, invalid root pte");
		bus_write(32'h0080_0040, SATP_VIRT, $urandom, 4'hf, random_hold(), resp);
		check_resp(resp, axi_pkg::SLVERR, "write, invalid root pte");
		// vpn0 2 has an invalid leaf pointing at 0x3000
		bus_read(32'h0040_2040, SATP_VIRT, random_hold(), data, resp);
		check_resp(resp, axi_pkg::SLVERR, "read, invalid leaf pte");
		check_word(data, 32'h0, "read data, invalid leaf pte");
		bus_write(32'h0040_2040, SATP_VIRT, $urandom, 4'hf, random_hold(), resp);
		check_resp(resp, axi_pkg::SLVERR, "write, invalid leaf pte");
		read_expect(32'h0040_0040, SATP_VIRT, 32'h0000_3040, random_hold(), "target unchanged");
	endtask

	task automatic back_pressure();
		axi_pkg::resp_e resp;
		logic [31:0]    d;
		logic [31:0]    va;
		logic [31:0]    pa;
		for (int i = 0; i < 4; i++) begin
			va = 32'h0040_0080 + 32'(i * 4);
			pa = 32'h0000_3080 + 32'(i * 4);
			d = $urandom;
			bus_write(va, SATP_VIRT, d, 4'hf, $urandom_range(1, 5), resp);
			check_resp(resp, axi_pkg::OKAY, "write under back-pressure");
			model_write(pa, d, 4'hf);
			read_expect(va, SATP_VIRT, pa, $urandom_range(1, 5), "read under back-pressure");
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(32'h5f191334));
		rst = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		arsize = axi_pkg::SIZE_WORD;
		arlen = '0;
		arburst = 2'b01;
		arsatp = '0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		awsatp = '0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// bare mode first since virtual mode is sticky
		bare_readback();
		bare_out_of_range();
		translated_read();
		translated_write();
		invalid_pte();
		back_pressure();

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
